/* src/exec_consts.svh */
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// physical register file
`define EXEC_NUM_PREGS 64
`define EXEC_PREG_W 6
`define EXEC_DATA_W 16

// completion tag width, same as a reorder buffer index
`define EXEC_TAG_W 6

// radix-16 multiplier iterations
`define EXEC_MULT_STEPS 4

`endif

/* src/exec_pkg.sv */
package exec_pkg;

	// opcodes of renamed instructions
	typedef enum logic [3:0] {
		op_add = 4'd0,
		op_sub = 4'd1,
		op_and = 4'd2,
		op_or  = 4'd3,
		op_xor = 4'd4,
		op_shl = 4'd5,
		op_shr = 4'd6,
		op_ldi = 4'd7,
		op_mul = 4'd8
	} op_t;

	// iterative multiplier FSM
	typedef enum logic {
		mult_idle = 1'b0,
		mult_run  = 1'b1
	} mult_state_t;

endpackage

/* src/issue_gate.sv */
`timescale 1ns/1ps
`include "exec_consts.svh"

module issue_gate (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  exec_pkg::op_t           in_op,
	input  logic [`EXEC_PREG_W-1:0] in_dst,
	input  logic [`EXEC_PREG_W-1:0] in_src1,
	input  logic [`EXEC_PREG_W-1:0] in_src2,
	input  logic [`EXEC_DATA_W-1:0] in_imm,
	input  logic                    in_imm_vld,
	input  logic [`EXEC_TAG_W-1:0]  in_tag,
	input  logic                    mult_busy,
	input  logic                    alu_done_vld,
	input  logic [`EXEC_PREG_W-1:0] alu_done_dst,
	input  logic                    mult_done_vld,
	input  logic [`EXEC_PREG_W-1:0] mult_done_dst,
	output logic                    in_ready,
	output logic                    alu_issue,
	output logic                    mult_issue,
	output exec_pkg::op_t           iss_op,
	output logic [`EXEC_PREG_W-1:0] iss_dst,
	output logic [`EXEC_TAG_W-1:0]  iss_tag,
	output logic [`EXEC_DATA_W-1:0] iss_imm,
	output logic                    iss_imm_vld,
	output logic [`EXEC_PREG_W-1:0] iss_src1,
	output logic [`EXEC_PREG_W-1:0] iss_src2
);

	logic [`EXEC_NUM_PREGS-1:0] busy;
	logic is_mul;
	logic src1_used;
	logic src2_used;
	logic src_hazard;
	logic mul_blocked;
	logic accept;

	assign is_mul = (in_op == exec_pkg::op_mul);
	assign src1_used = (in_op != exec_pkg::op_ldi);
	// multiplier always reads src2, imm or not
	assign src2_used = src1_used && (!in_imm_vld || is_mul);

	assign src_hazard = (src1_used && busy[in_src1]) || (src2_used && busy[in_src2]);
	assign mul_blocked = is_mul && (mult_busy || mult_issue);
	assign in_ready = !src_hazard && !busy[in_dst] && !mul_blocked;
	assign accept = in_valid && in_ready;

	// scoreboard, set on accept and cleared by either completion
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= '0;
		end else begin
			if (alu_done_vld)
				busy[alu_done_dst] <= 1'b0;
			if (mult_done_vld)
				busy[mult_done_dst] <= 1'b0;
			if (accept)
				busy[in_dst] <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alu_issue <= 1'b0;
			mult_issue <= 1'b0;
		end else begin
			alu_issue <= accept && !is_mul;
			mult_issue <= accept && is_mul;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			iss_op <= in_op;
			iss_dst <= in_dst;
			iss_tag <= in_tag;
			iss_imm <= in_imm;
			iss_imm_vld <= in_imm_vld;
			iss_src1 <= in_src1;
			iss_src2 <= in_src2;
		end
	end

	// multiplier must be idle when a new multiply reaches it
	a_mult_idle: assert property (@(posedge clk) disable iff (!rst_n)
		mult_issue |-> exec_pkg::mult_state_t'(mult_busy) == exec_pkg::mult_idle);

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps
`include "exec_consts.svh"

module reg_file (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`EXEC_PREG_W-1:0] rd_addr_a,
	input  logic [`EXEC_PREG_W-1:0] rd_addr_b,
	input  logic [`EXEC_PREG_W-1:0] rd_addr_c,
	input  logic [`EXEC_PREG_W-1:0] rd_addr_d,
	input  logic                    wr0_en,
	input  logic [`EXEC_PREG_W-1:0] wr0_addr,
	input  logic [`EXEC_DATA_W-1:0] wr0_data,
	input  logic                    wr1_en,
	input  logic [`EXEC_PREG_W-1:0] wr1_addr,
	input  logic [`EXEC_DATA_W-1:0] wr1_data,
	output logic [`EXEC_DATA_W-1:0] rd_data_a,
	output logic [`EXEC_DATA_W-1:0] rd_data_b,
	output logic [`EXEC_DATA_W-1:0] rd_data_c,
	output logic [`EXEC_DATA_W-1:0] rd_data_d
);

	logic [`EXEC_DATA_W-1:0] regs [`EXEC_NUM_PREGS];

	// a/b for the ALU, c/d for the multiplier
	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];
	assign rd_data_c = regs[rd_addr_c];
	assign rd_data_d = regs[rd_addr_d];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `EXEC_NUM_PREGS; i++)
				regs[i] <= '0;
		end else begin
			if (wr0_en)
				regs[wr0_addr] <= wr0_data;
			if (wr1_en)
				regs[wr1_addr] <= wr1_data;
		end
	end

	// scoreboard keeps the two lanes on different destinations
	a_wr_distinct: assert property (@(posedge clk) disable iff (!rst_n)
		(wr0_en && wr1_en) |-> (wr0_addr != wr1_addr));

endmodule

/* src/alu_unit.sv */
`timescale 1ns/1ps
`include "exec_consts.svh"

module alu_unit (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    alu_issue,
	input  exec_pkg::op_t           iss_op,
	input  logic [`EXEC_PREG_W-1:0] iss_dst,
	input  logic [`EXEC_TAG_W-1:0]  iss_tag,
	input  logic [`EXEC_DATA_W-1:0] iss_imm,
	input  logic                    iss_imm_vld,
	input  logic [`EXEC_DATA_W-1:0] op_a,
	input  logic [`EXEC_DATA_W-1:0] op_b,
	output logic                    alu_done_vld,
	output logic [`EXEC_TAG_W-1:0]  alu_done_tag,
	output logic [`EXEC_PREG_W-1:0] alu_done_dst,
	output logic [`EXEC_DATA_W-1:0] alu_done_data
);

	localparam int SHAMT_W = $clog2(`EXEC_DATA_W);

	logic [`EXEC_DATA_W-1:0] opnd_b;
	logic [SHAMT_W-1:0] shamt;
	logic [`EXEC_DATA_W-1:0] result;

	assign opnd_b = iss_imm_vld ? iss_imm : op_b;
	assign shamt = opnd_b[SHAMT_W-1:0];

	always_comb begin
		case (iss_op)
			exec_pkg::op_add: result = op_a + opnd_b;
			exec_pkg::op_sub: result = op_a - opnd_b;
			exec_pkg::op_and: result = op_a & opnd_b;
			exec_pkg::op_or:  result = op_a | opnd_b;
			exec_pkg::op_xor: result = op_a ^ opnd_b;
			exec_pkg::op_shl: result = op_a << shamt;
			exec_pkg::op_shr: result = op_a >> shamt;
			exec_pkg::op_ldi: result = iss_imm;
			default:          result = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			alu_done_vld <= 1'b0;
		else
			alu_done_vld <= alu_issue;
	end

	always_ff @(posedge clk) begin
		if (alu_issue) begin
			alu_done_tag <= iss_tag;
			alu_done_dst <= iss_dst;
			alu_done_data <= result;
		end
	end

endmodule

/* src/mult_unit.sv */
`timescale 1ns/1ps
`include "exec_consts.svh"

module mult_unit (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    mult_issue,
	input  logic [`EXEC_PREG_W-1:0] iss_dst,
	input  logic [`EXEC_TAG_W-1:0]  iss_tag,
	input  logic [`EXEC_DATA_W-1:0] op_a,
	input  logic [`EXEC_DATA_W-1:0] op_b,
	output logic                    mult_busy,
	output logic                    mult_done_vld,
	output logic [`EXEC_TAG_W-1:0]  mult_done_tag,
	output logic [`EXEC_PREG_W-1:0] mult_done_dst,
	output logic [`EXEC_DATA_W-1:0] mult_done_data
);

	localparam int STEP_W = $clog2(`EXEC_MULT_STEPS);
	localparam int DIGIT_W = `EXEC_DATA_W / `EXEC_MULT_STEPS;

	exec_pkg::mult_state_t state;
	logic [STEP_W-1:0] step_cnt;
	logic [`EXEC_DATA_W-1:0] mcand;
	logic [`EXEC_DATA_W-1:0] mplier;
	logic [`EXEC_DATA_W-1:0] acc;
	logic [`EXEC_DATA_W-1:0] partial;
	logic last_step;

	// multiplicand times the low digit, already shifted into place
	assign partial = mcand * {{(`EXEC_DATA_W-DIGIT_W){1'b0}}, mplier[DIGIT_W-1:0]};
	assign last_step = (step_cnt == STEP_W'(`EXEC_MULT_STEPS - 1));
	assign mult_busy = (state == exec_pkg::mult_run);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= exec_pkg::mult_idle;
			step_cnt <= '0;
			mult_done_vld <= 1'b0;
		end else begin
			mult_done_vld <= 1'b0;
			case (state)
				exec_pkg::mult_idle: begin
					step_cnt <= '0;
					if (mult_issue)
						state <= exec_pkg::mult_run;
				end
				exec_pkg::mult_run: begin
					step_cnt <= step_cnt + 1'b1;
					if (last_step) begin
						state <= exec_pkg::mult_idle;
						mult_done_vld <= 1'b1;
					end
				end
				default: state <= exec_pkg::mult_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (mult_issue) begin
			mcand <= op_a;
			mplier <= op_b;
			acc <= '0;
			mult_done_tag <= iss_tag;
			mult_done_dst <= iss_dst;
		end else if (mult_busy) begin
			mcand <= mcand << DIGIT_W;
			mplier <= mplier >> DIGIT_W;
			acc <= acc + partial;
			if (last_step)
				mult_done_data <= acc + partial;
		end
	end

endmodule

/* src/exec_cluster.sv */
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_cluster (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	output logic                    in_ready,
	input  exec_pkg::op_t           in_op,
	input  logic [`EXEC_PREG_W-1:0] in_dst,
	input  logic [`EXEC_PREG_W-1:0] in_src1,
	input  logic [`EXEC_PREG_W-1:0] in_src2,
	input  logic [`EXEC_DATA_W-1:0] in_imm,
	input  logic                    in_imm_vld,
	input  logic [`EXEC_TAG_W-1:0]  in_tag,
	output logic                    alu_done_vld,
	output logic [`EXEC_TAG_W-1:0]  alu_done_tag,
	output logic [`EXEC_PREG_W-1:0] alu_done_dst,
	output logic [`EXEC_DATA_W-1:0] alu_done_data,
	output logic                    mult_done_vld,
	output logic [`EXEC_TAG_W-1:0]  mult_done_tag,
	output logic [`EXEC_PREG_W-1:0] mult_done_dst,
	output logic [`EXEC_DATA_W-1:0] mult_done_data
);

	logic alu_issue;
	logic mult_issue;
	logic mult_busy;
	exec_pkg::op_t iss_op;
	logic [`EXEC_PREG_W-1:0] iss_dst;
	logic [`EXEC_TAG_W-1:0] iss_tag;
	logic [`EXEC_DATA_W-1:0] iss_imm;
	logic iss_imm_vld;
	logic [`EXEC_PREG_W-1:0] iss_src1;
	logic [`EXEC_PREG_W-1:0] iss_src2;
	logic [`EXEC_DATA_W-1:0] alu_op_a;
	logic [`EXEC_DATA_W-1:0] alu_op_b;
	logic [`EXEC_DATA_W-1:0] mult_op_a;
	logic [`EXEC_DATA_W-1:0] mult_op_b;

	issue_gate u_issue_gate (
		.clk(clk), .rst_n(rst_n),
		.in_valid(in_valid), .in_op(in_op), .in_dst(in_dst),
		.in_src1(in_src1), .in_src2(in_src2),
		.in_imm(in_imm), .in_imm_vld(in_imm_vld), .in_tag(in_tag),
		.mult_busy(mult_busy),
		.alu_done_vld(alu_done_vld), .alu_done_dst(alu_done_dst),
		.mult_done_vld(mult_done_vld), .mult_done_dst(mult_done_dst),
		.in_ready(in_ready), .alu_issue(alu_issue), .mult_issue(mult_issue),
		.iss_op(iss_op), .iss_dst(iss_dst), .iss_tag(iss_tag),
		.iss_imm(iss_imm), .iss_imm_vld(iss_imm_vld),
		.iss_src1(iss_src1), .iss_src2(iss_src2)
	);

	// alu lane writes port 0, multiplier port 1
	reg_file u_reg_file (
		.clk(clk), .rst_n(rst_n),
		.rd_addr_a(iss_src1), .rd_addr_b(iss_src2),
		.rd_addr_c(iss_src1), .rd_addr_d(iss_src2),
		.wr0_en(alu_done_vld), .wr0_addr(alu_done_dst), .wr0_data(alu_done_data),
		.wr1_en(mult_done_vld), .wr1_addr(mult_done_dst), .wr1_data(mult_done_data),
		.rd_data_a(alu_op_a), .rd_data_b(alu_op_b),
		.rd_data_c(mult_op_a), .rd_data_d(mult_op_b)
	);

	alu_unit u_alu_unit (
		.clk(clk), .rst_n(rst_n),
		.alu_issue(alu_issue), .iss_op(iss_op), .iss_dst(iss_dst), .iss_tag(iss_tag),
		.iss_imm(iss_imm), .iss_imm_vld(iss_imm_vld),
		.op_a(alu_op_a), .op_b(alu_op_b),
		.alu_done_vld(alu_done_vld), .alu_done_tag(alu_done_tag),
		.alu_done_dst(alu_done_dst), .alu_done_data(alu_done_data)
	);

	mult_unit u_mult_unit (
		.clk(clk), .rst_n(rst_n),
		.mult_issue(mult_issue), .iss_dst(iss_dst), .iss_tag(iss_tag),
		.op_a(mult_op_a), .op_b(mult_op_b),
		.mult_busy(mult_busy), .mult_done_vld(mult_done_vld),
		.mult_done_tag(mult_done_tag), .mult_done_dst(mult_done_dst),
		.mult_done_data(mult_done_data)
	);

endmodule

/* verif/tb_exec_cluster.sv */
`timescale 1ns/1ps
`include "exec_consts.svh"

module tb_exec_cluster;

	localparam int NUM_INSTR = 300;
	localparam int WAIT_LIMIT = 200;
	localparam int NUM_TAGS = 1 << `EXEC_TAG_W;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	exec_pkg::op_t in_op;
	logic [`EXEC_PREG_W-1:0] in_dst;
	logic [`EXEC_PREG_W-1:0] in_src1;
	logic [`EXEC_PREG_W-1:0] in_src2;
	logic [`EXEC_DATA_W-1:0] in_imm;
	logic in_imm_vld;
	logic [`EXEC_TAG_W-1:0] in_tag;
	logic alu_done_vld;
	logic [`EXEC_TAG_W-1:0] alu_done_tag;
	logic [`EXEC_PREG_W-1:0] alu_done_dst;
	logic [`EXEC_DATA_W-1:0] alu_done_data;
	logic mult_done_vld;
	logic [`EXEC_TAG_W-1:0] mult_done_tag;
	logic [`EXEC_PREG_W-1:0] mult_done_dst;
	logic [`EXEC_DATA_W-1:0] mult_done_data;

	// shadow register file and per-tag expectations
	logic [`EXEC_DATA_W-1:0] shadow [`EXEC_NUM_PREGS];
	logic exp_pend [NUM_TAGS];
	logic exp_mul [NUM_TAGS];
	logic [`EXEC_PREG_W-1:0] exp_dst [NUM_TAGS];
	logic [`EXEC_DATA_W-1:0] exp_data [NUM_TAGS];
	int val_errs = 0;
	int other_errs = 0;
	int issued = 0;
	int completed = 0;
	int cycle_cnt = 0;
	int last_mul = -100;
	bit timed_out = 0;

	exec_cluster uut (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	function automatic logic [`EXEC_DATA_W-1:0] ref_result(input exec_pkg::op_t op,
			input logic [`EXEC_DATA_W-1:0] a, input logic [`EXEC_DATA_W-1:0] b,
			input logic [`EXEC_DATA_W-1:0] imm, input logic imm_vld);
		logic [`EXEC_DATA_W-1:0] opnd;
		logic [2*`EXEC_DATA_W-1:0] prod;
		opnd = imm_vld ? imm : b;
		prod = {{`EXEC_DATA_W{1'b0}}, a} * {{`EXEC_DATA_W{1'b0}}, b};
		case (op)
			exec_pkg::op_add: return a + opnd;
			exec_pkg::op_sub: return a - opnd;
			exec_pkg::op_and: return a & opnd;
			exec_pkg::op_or:  return a | opnd;
			exec_pkg::op_xor: return a ^ opnd;
			exec_pkg::op_shl: return a << opnd[3:0];
			exec_pkg::op_shr: return a >> opnd[3:0];
			exec_pkg::op_ldi: return imm;
			// multiplier takes src2 from the register file, imm or not
			exec_pkg::op_mul: return prod[`EXEC_DATA_W-1:0];
			default:          return '0;
		endcase
	endfunction

	task automatic record_accept();
		logic [`EXEC_DATA_W-1:0] data;
		if (exp_pend[in_tag]) begin
			$display("tag %0d accepted again while still outstanding", in_tag);
			other_errs++;
		end
		if (in_op == exec_pkg::op_mul) begin
			if (cycle_cnt - last_mul < 5) begin
				$display("op_mul accepted %0d edges after the previous one", cycle_cnt - last_mul);
				other_errs++;
			end
			last_mul = cycle_cnt;
		end
		data = ref_result(in_op, shadow[in_src1], shadow[in_src2], in_imm, in_imm_vld);
		shadow[in_dst] = data;
		exp_pend[in_tag] = 1'b1;
		exp_mul[in_tag] = (in_op == exec_pkg::op_mul);
		exp_dst[in_tag] = in_dst;
		exp_data[in_tag] = data;
		issued++;
	endtask

	task automatic check_done(input logic is_mul, input logic [`EXEC_TAG_W-1:0] tag,
			input logic [`EXEC_PREG_W-1:0] dst, input logic [`EXEC_DATA_W-1:0] data);
		if (!exp_pend[tag]) begin
			$display("completion for tag %0d that is not outstanding", tag);
			other_errs++;
		end else begin
			if (exp_mul[tag] != is_mul) begin
				$display("tag %0d completed on the wrong lane", tag);
				other_errs++;
			end
			if (dst != exp_dst[tag]) begin
				$display("[ERROR] %s_done_dst tag %0d expected %h got %h",
					is_mul ? "mult" : "alu", tag, exp_dst[tag], dst);
				val_errs++;
			end
			if (data != exp_data[tag]) begin
				$display("[ERROR] %s_done_data tag %0d expected %h got %h",
					is_mul ? "mult" : "alu", tag, exp_data[tag], data);
				val_errs++;
			end
			exp_pend[tag] = 1'b0;
			completed++;
		end
	endtask

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clk) begin
		if (rst_n) begin
			if (alu_done_vld)
				check_done(1'b0, alu_done_tag, alu_done_dst, alu_done_data);
			if (mult_done_vld)
				check_done(1'b1, mult_done_tag, mult_done_dst, mult_done_data);
		end
	end

	task automatic send_instr(input exec_pkg::op_t op, input logic [`EXEC_PREG_W-1:0] dst,
			input logic [`EXEC_PREG_W-1:0] src1, input logic [`EXEC_PREG_W-1:0] src2,
			input logic [`EXEC_DATA_W-1:0] imm, input logic imm_vld);
		int waited;
		bit done;
		waited = 0;
		done = 0;
		in_valid = 1'b1;
		in_op = op;
		in_dst = dst;
		in_src1 = src1;
		in_src2 = src2;
		in_imm = imm;
		in_imm_vld = imm_vld;
		in_tag = `EXEC_TAG_W'(issued % NUM_TAGS);
		while (!done && !timed_out) begin
			@(negedge clk);
			waited++;
			if (in_ready) begin
				record_accept();
				done = 1;
			end else if (waited > WAIT_LIMIT) begin
				$display("in_ready stayed low for %0d cycles", waited);
				other_errs++;
				timed_out = 1;
			end
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	initial begin
		int waited;
		void'($urandom(32'h427e26e7));
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_op = exec_pkg::op_add;
		in_dst = '0;
		in_src1 = '0;
		in_src2 = '0;
		in_imm = '0;
		in_imm_vld = 1'b0;
		in_tag = '0;
		for (int i = 0; i < `EXEC_NUM_PREGS; i++)
			shadow[i] = '0;
		for (int i = 0; i < NUM_TAGS; i++)
			exp_pend[i] = 1'b0;
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;
		@(negedge clk);
		if (in_ready !== 1'b1) begin
			$display("[ERROR] in_ready expected %h got %h", 1'b1, in_ready);
			val_errs++;
		end
		if (alu_done_vld !== 1'b0) begin
			$display("[ERROR] alu_done_vld expected %h got %h", 1'b0, alu_done_vld);
			val_errs++;
		end
		if (mult_done_vld !== 1'b0) begin
			$display("[ERROR] mult_done_vld expected %h got %h", 1'b0, mult_done_vld);
			val_errs++;
		end
		@(posedge clk);
		#1;
		for (int r = 0; r < 8; r++)
			send_instr(exec_pkg::op_ldi, `EXEC_PREG_W'(r), '0, '0, `EXEC_DATA_W'($urandom), 1'b1);
		// registers 0 to 7 only, so hazards are frequent
		for (int i = 0; i < NUM_INSTR && !timed_out; i++) begin
			if ($urandom_range(0, 3) == 0) begin
				repeat ($urandom_range(1, 3)) @(posedge clk);
				#1;
			end
			send_instr(exec_pkg::op_t'($urandom_range(0, 8)),
				`EXEC_PREG_W'($urandom_range(0, 7)), `EXEC_PREG_W'($urandom_range(0, 7)),
				`EXEC_PREG_W'($urandom_range(0, 7)), `EXEC_DATA_W'($urandom),
				1'($urandom_range(0, 1)));
		end
		waited = 0;
		while (!timed_out && completed != issued) begin
			@(negedge clk);
			waited++;
			if (waited > WAIT_LIMIT) begin
				$display("%0d instructions still outstanding at end of run", issued - completed);
				other_errs++;
				timed_out = 1;
			end
		end
		$display("issued %0d, completed %0d, value errors %0d, other errors %0d",
			issued, completed, val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* build.f */
+incdir+src
src/exec_pkg.sv
src/issue_gate.sv
src/reg_file.sv
src/alu_unit.sv
src/mult_unit.sv
src/exec_cluster.sv
verif/tb_exec_cluster.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_exec_cluster
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
